// File: hw/spiSlavePkg.sv
//--------------------------------------------------------------------------
// Shared types for the SPI slave subsystem
// Imported by the parser, mux, CSR block, write buffer and top level
//--------------------------------------------------------------------------
`default_nettype none

package spiSlavePkg;

	// Width of the USI register address
	localparam int csrAdrsBit = 8;

	// Header opcode in bits 31:30 of word 0
	typedef enum logic [1:0]
	{
		cmdNop      = 2'd0,
		cmdCsrWrite = 2'd1,
		cmdCsrRead  = 2'd2,
		cmdUfiWrite = 2'd3
	} spiCmdE;

	// Parser position inside a frame
	typedef enum logic [1:0]
	{
		stIdle,
		stAddr,
		stData
	} cmdStateE;

	// One parsed data word with its context
	typedef struct packed
	{
		logic [31:0] rd;
		logic [31:0] adrs;
		spiCmdE      cmd;
		// Words left in the frame, current one included
		logic [15:0] dLen;
		logic        rdVd;
	} spiFrameS;

	// CSR write bus
	typedef struct packed
	{
		logic [31:0]           wd;
		logic [csrAdrsBit-1:0] adrs;
		logic                  wEd;
	} usiBusS;

	// Burst write bus
	typedef struct packed
	{
		logic [31:0] wd;
		logic [31:0] adrs;
		logic        wEd;
		// High for the span of a burst
		logic        wVd;
	} ufiBusS;

	// Word handed to the external consumer
	typedef struct packed
	{
		logic [31:0] wd;
		logic [31:0] adrs;
		logic        valid;
	} ufiOutS;

endpackage

`default_nettype wire

// File: hw/spiSlaveShift.sv
//--------------------------------------------------------------------------
// SPI mode 0 shifter, brings sclk/mosi/csN into iSysClk and builds words
// Emits a one-cycle rxVd per 32-bit word and shifts txWord out on MISO
//--------------------------------------------------------------------------
`default_nettype none

module spiSlaveShift
(
	input  wire        iSysClk,
	input  wire        rstN,
	// SPI pins
	input  wire        sclk,
	input  wire        mosi,
	input  wire        csN,
	output logic       miso,
	// Word side
	input  wire [31:0] txWord,
	output logic [31:0] rxWord,
	output logic       rxVd,
	output logic       frameStart
);

	// Two sync flops plus one history flop for edge detect
	logic [2:0]  sclkSync;
	logic [1:0]  mosiSync;
	logic [2:0]  csSync;
	logic        sclkRise;
	logic        sclkFall;
	logic        csHigh;
	logic        csFall;
	// Bit position within the current word
	logic [4:0]  bitCnt;
	logic [31:0] shiftRx;
	logic [31:0] shiftTx;

	assign sclkRise = sclkSync[1] & ~sclkSync[2];
	assign sclkFall = ~sclkSync[1] & sclkSync[2];
	assign csHigh   = csSync[1];
	assign csFall   = ~csSync[1] & csSync[2];

	//--------------------------------------------------------------------------
	// Synchronizers, bit counter and MISO shifter
	//--------------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			// Idle bus levels
			sclkSync   <= 3'b000;
			mosiSync   <= 2'b00;
			csSync     <= 3'b111;
			bitCnt     <= 5'd0;
			rxVd       <= 1'b0;
			frameStart <= 1'b0;
			shiftTx    <= 32'd0;
		end
		else
		begin
			sclkSync   <= {sclkSync[1:0], sclk};
			mosiSync   <= {mosiSync[0], mosi};
			csSync     <= {csSync[1:0], csN};
			frameStart <= csFall;
			rxVd       <= 1'b0;

			if (csHigh)
			begin
				bitCnt <= 5'd0;
			end
			else if (sclkRise)
			begin
				bitCnt <= bitCnt + 5'd1;
				// 32nd bit closes the word
				if (bitCnt == 5'd31)
				begin
					rxVd <= 1'b1;
				end
			end

			// First word is ready before the first rising edge
			if (csFall)
			begin
				shiftTx <= txWord;
			end
			else if (sclkFall && !csHigh)
			begin
				// Counter wrapped, so a new word starts here
				if (bitCnt == 5'd0)
				begin
					shiftTx <= txWord;
				end
				else
				begin
					shiftTx <= {shiftTx[30:0], 1'b0};
				end
			end
		end
	end

	// Receive shifter, MSB first
	always_ff @(posedge iSysClk)
	begin
		if (sclkRise && !csHigh)
		begin
			shiftRx <= {shiftRx[30:0], mosiSync[1]};
		end
	end

	// Only meaningful while rxVd is high
	assign rxWord = shiftRx;
	assign miso   = shiftTx[31];

	// Words complete only inside a selected frame
	aRxInFrame: assert property (@(posedge iSysClk) disable iff (!rstN)
		rxVd |-> !csHigh)
		else $error("rxVd outside of a frame");

endmodule

`default_nettype wire

// File: hw/spiSlaveCmd.sv
//--------------------------------------------------------------------------
// Frame parser, turns header and address words into per-word commands
// Data words leave with auto-incremented address and remaining length
//--------------------------------------------------------------------------
`default_nettype none

module spiSlaveCmd import spiSlavePkg::*;
(
	input  wire        iSysClk,
	input  wire        rstN,
	input  wire [31:0] rxWord,
	input  wire        rxVd,
	input  wire        frameStart,
	output spiFrameS   frame
);

	cmdStateE    state;
	spiCmdE      cmdR;
	logic [31:0] adrsR;
	logic [15:0] dLenR;
	// Registered frame fields
	logic [31:0] frameRd;
	logic [31:0] frameAdrs;
	spiCmdE      frameCmd;
	logic [15:0] frameDLen;
	logic        frameRdVd;
	logic        emitRead;
	logic        emitData;

	// CSR read issues its single access on the address word
	assign emitRead = rxVd && (state == stAddr) && (cmdR == cmdCsrRead);
	// Writes issue one frame per data word until dLen runs out
	assign emitData = rxVd && (state == stData) && (dLenR != 16'd0);

	//--------------------------------------------------------------------------
	// Parser FSM
	//--------------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state     <= stIdle;
			cmdR      <= cmdNop;
			dLenR     <= 16'd0;
			frameCmd  <= cmdNop;
			frameDLen <= 16'd0;
			frameRdVd <= 1'b0;
		end
		else
		begin
			// Pre-decrement count during rdVd, remaining count after
			frameCmd  <= cmdR;
			frameDLen <= dLenR;
			frameRdVd <= emitRead | emitData;

			if (frameStart)
			begin
				state <= stIdle;
				cmdR  <= cmdNop;
				dLenR <= 16'd0;
			end
			else if (rxVd)
			begin
				case (state)
					stIdle:
					begin
						cmdR  <= spiCmdE'(rxWord[31:30]);
						// Nop carries no data
						dLenR <= (rxWord[31:30] == 2'd0) ? 16'd0 : rxWord[15:0];
						state <= stAddr;
					end
					stAddr:
					begin
						state <= stData;
						// Dummy words after a read are ignored
						if (cmdR == cmdCsrRead)
						begin
							dLenR <= 16'd0;
						end
					end
					stData:
					begin
						if (dLenR != 16'd0)
						begin
							dLenR <= dLenR - 16'd1;
						end
					end
					default:
					begin
						state <= stIdle;
					end
				endcase
			end
		end
	end

	// Address and data path
	always_ff @(posedge iSysClk)
	begin
		if (rxVd && (state == stAddr))
		begin
			adrsR <= rxWord;
		end
		else if (emitData)
		begin
			adrsR <= adrsR + 32'd1;
		end

		if (emitRead)
		begin
			frameRd   <= 32'd0;
			frameAdrs <= rxWord;
		end
		else if (emitData)
		begin
			frameRd   <= rxWord;
			frameAdrs <= adrsR;
		end
	end

	assign frame.rd   = frameRd;
	assign frame.adrs = frameAdrs;
	assign frame.cmd  = frameCmd;
	assign frame.dLen = frameDLen;
	assign frame.rdVd = frameRdVd;

endmodule

`default_nettype wire

// File: hw/spiSignalMux.sv
//--------------------------------------------------------------------------
// Routes parsed frames to the USI CSR bus or the UFI burst bus
// Holds write buffer slot credits and flags words dropped without credit
//--------------------------------------------------------------------------
`default_nettype none

module spiSignalMux import spiSlavePkg::*;
#(
	parameter int pBufDepth = 8
)
(
	input  wire        iSysClk,
	input  wire        rstN,
	input  spiFrameS   frame,
	output logic [31:0] txWord,
	input  wire [31:0] csrRd,
	output usiBusS     usi,
	output ufiBusS     ufi,
	input  wire        slotFree,
	output logic       overflow
);

	localparam int pCreditBits = $clog2(pBufDepth + 1);

	logic [pCreditBits-1:0] credit;
	logic                   csrHit;
	logic                   ufiHit;
	logic                   ufiAccept;
	logic                   ufiDrop;
	// Registered bus fields
	logic [31:0]            usiWd;
	logic [csrAdrsBit-1:0]  usiAdrs;
	logic                   usiWEd;
	logic [31:0]            ufiWd;
	logic [31:0]            ufiAdrs;
	logic                   ufiWEd;
	logic                   ufiWVd;

	assign csrHit    = frame.rdVd && ((frame.cmd == cmdCsrWrite) || (frame.cmd == cmdCsrRead));
	assign ufiHit    = frame.rdVd && (frame.cmd == cmdUfiWrite);
	assign ufiAccept = ufiHit && (credit != '0);
	// Master cannot be stalled, so a word without credit is lost
	assign ufiDrop   = ufiHit && (credit == '0);

	// CSR read data goes straight back to the shifter
	assign txWord = csrRd;

	//--------------------------------------------------------------------------
	// Registered decode stage
	//--------------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			usiAdrs  <= '0;
			usiWEd   <= 1'b0;
			ufiWEd   <= 1'b0;
			ufiWVd   <= 1'b0;
			overflow <= 1'b0;
			credit   <= pCreditBits'(pBufDepth);
		end
		else
		begin
			usiWEd   <= frame.rdVd && (frame.cmd == cmdCsrWrite);
			ufiWEd   <= ufiAccept;
			ufiWVd   <= (frame.cmd == cmdUfiWrite) && (frame.dLen != 16'd0);
			overflow <= ufiDrop;

			// Read address also steers csrRd
			if (csrHit)
			begin
				usiAdrs <= frame.adrs[csrAdrsBit-1:0];
			end

			// Slot returned vs slot spent
			case ({slotFree, ufiAccept})
				2'b10:   credit <= credit + 1'b1;
				2'b01:   credit <= credit - 1'b1;
				default: credit <= credit;
			endcase
		end
	end

	always_ff @(posedge iSysClk)
	begin
		if (csrHit)
		begin
			usiWd <= frame.rd;
		end
		if (ufiHit)
		begin
			ufiWd   <= frame.rd;
			ufiAdrs <= frame.adrs;
		end
	end

	assign usi = '{wd: usiWd, adrs: usiAdrs, wEd: usiWEd};
	assign ufi = '{wd: ufiWd, adrs: ufiAdrs, wEd: ufiWEd, wVd: ufiWVd};

	// Buffer never returns more slots than it has
	aCreditMax: assert property (@(posedge iSysClk) disable iff (!rstN)
		credit <= pCreditBits'(pBufDepth))
		else $error("slot credit above buffer depth");

endmodule

`default_nettype wire

// File: hw/csrRegFile.sv
//--------------------------------------------------------------------------
// CSR block on the USI bus, four scratch words plus overflow status
//--------------------------------------------------------------------------
`default_nettype none

module csrRegFile import spiSlavePkg::*;
(
	input  wire        iSysClk,
	input  wire        rstN,
	input  usiBusS     usi,
	output logic [31:0] csrRd,
	input  wire        overflow
);

	// Register map
	localparam logic [csrAdrsBit-1:0] adrsStatus = csrAdrsBit'(4);
	localparam logic [csrAdrsBit-1:0] adrsOvfCnt = csrAdrsBit'(5);

	logic [31:0] scratch [4];
	logic        ovfFlag;
	logic [31:0] ovfCount;

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 4; i++)
			begin
				scratch[i] <= 32'd0;
			end
			ovfFlag  <= 1'b0;
			ovfCount <= 32'd0;
		end
		else
		begin
			// Scratch at 0..3
			if (usi.wEd && (usi.adrs < adrsStatus))
			begin
				scratch[usi.adrs[1:0]] <= usi.wd;
			end

			// Sticky flag, new overflow wins over a clear
			if (overflow)
			begin
				ovfFlag <= 1'b1;
			end
			else if (usi.wEd && (usi.adrs == adrsStatus) && usi.wd[0])
			begin
				ovfFlag <= 1'b0;
			end

			if (overflow)
			begin
				ovfCount <= ovfCount + 32'd1;
			end
		end
	end

	// Read on the last registered address
	always_comb
	begin
		if (usi.adrs < adrsStatus)
			csrRd = scratch[usi.adrs[1:0]];
		else if (usi.adrs == adrsStatus)
			csrRd = {31'd0, ovfFlag};
		else if (usi.adrs == adrsOvfCnt)
			csrRd = ovfCount;
		else
			csrRd = 32'd0;
	end

endmodule

`default_nettype wire

// File: hw/ufiWriteBuffer.sv
//--------------------------------------------------------------------------
// UFI write FIFO, drains one word per cycle while consumer credits remain
// Each drained word returns a slot credit to the mux via slotFree
//--------------------------------------------------------------------------
`default_nettype none

module ufiWriteBuffer import spiSlavePkg::*;
#(
	parameter int pBufDepth   = 8,
	parameter int pOutCredits = 4
)
(
	input  wire   iSysClk,
	input  wire   rstN,
	input  ufiBusS ufi,
	output logic  slotFree,
	output ufiOutS ufiOut,
	input  wire   ufiCreditRet
);

	localparam int pPtrBits = (pBufDepth > 1) ? $clog2(pBufDepth) : 1;
	localparam int pCntBits = $clog2(pBufDepth + 1);
	localparam int pCrdBits = $clog2(pOutCredits + 1);

	logic [31:0]         memWd   [pBufDepth];
	logic [31:0]         memAdrs [pBufDepth];
	logic [pPtrBits-1:0] wrPtr;
	logic [pPtrBits-1:0] rdPtr;
	logic [pCntBits-1:0] count;
	// Credits granted by the consumer
	logic [pCrdBits-1:0] outCredit;
	logic                drain;

	// Every valid cycle is taken by the consumer
	assign drain    = (count != '0) && (outCredit != '0);
	assign slotFree = drain;

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			count     <= '0;
			outCredit <= pCrdBits'(pOutCredits);
		end
		else
		begin
			if (ufi.wEd)
			begin
				wrPtr <= (wrPtr == pPtrBits'(pBufDepth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (drain)
			begin
				rdPtr <= (rdPtr == pPtrBits'(pBufDepth - 1)) ? '0 : rdPtr + 1'b1;
			end

			case ({ufi.wEd, drain})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase

			// Spent on transfer, restored by ufiCreditRet
			case ({ufiCreditRet, drain})
				2'b10:   outCredit <= outCredit + 1'b1;
				2'b01:   outCredit <= outCredit - 1'b1;
				default: outCredit <= outCredit;
			endcase
		end
	end

	// Storage
	always_ff @(posedge iSysClk)
	begin
		if (ufi.wEd)
		begin
			memWd[wrPtr]   <= ufi.wd;
			memAdrs[wrPtr] <= ufi.adrs;
		end
	end

	assign ufiOut = '{wd: memWd[rdPtr], adrs: memAdrs[rdPtr], valid: drain};

	// Mux credits must keep writes off a full FIFO
	aNoWriteFull: assert property (@(posedge iSysClk) disable iff (!rstN)
		ufi.wEd |-> (count != pCntBits'(pBufDepth)))
		else $error("UFI write into a full buffer");

	// Writes only inside a burst
	aWriteInBurst: assert property (@(posedge iSysClk) disable iff (!rstN)
		ufi.wEd |-> ufi.wVd)
		else $error("UFI wEd without wVd");

endmodule

`default_nettype wire

// File: hw/spiSlaveTop.sv
//--------------------------------------------------------------------------
// SPI slave subsystem top, sets buffer depth and consumer credits
//--------------------------------------------------------------------------
`default_nettype none

module spiSlaveTop import spiSlavePkg::*;
#(
	parameter int pBufDepth   = 8,
	parameter int pOutCredits = 4
)
(
	input  wire    iSysClk,
	input  wire    rstN,
	input  wire    sclk,
	input  wire    mosi,
	input  wire    csN,
	input  wire    ufiCreditRet,
	output logic   miso,
	output ufiOutS ufiOut
);

	// Shifter to parser
	logic [31:0] rxWord;
	logic        rxVd;
	logic        frameStart;
	logic [31:0] txWord;
	// Parser to mux
	spiFrameS    frame;
	// Mux to upper blocks
	usiBusS      usi;
	ufiBusS      ufi;
	logic [31:0] csrRd;
	logic        slotFree;
	logic        overflow;

	spiSlaveShift uShift
	(
		.iSysClk(iSysClk), .rstN(rstN), .sclk(sclk), .mosi(mosi), .csN(csN),
		.miso(miso), .txWord(txWord), .rxWord(rxWord), .rxVd(rxVd),
		.frameStart(frameStart)
	);

	spiSlaveCmd uCmd
	(
		.iSysClk(iSysClk), .rstN(rstN), .rxWord(rxWord), .rxVd(rxVd),
		.frameStart(frameStart), .frame(frame)
	);

	spiSignalMux #(.pBufDepth(pBufDepth)) uMux
	(
		.iSysClk(iSysClk), .rstN(rstN), .frame(frame), .txWord(txWord),
		.csrRd(csrRd), .usi(usi), .ufi(ufi), .slotFree(slotFree), .overflow(overflow)
	);

	csrRegFile uCsr
	(
		.iSysClk(iSysClk), .rstN(rstN), .usi(usi), .csrRd(csrRd), .overflow(overflow)
	);

	ufiWriteBuffer #(.pBufDepth(pBufDepth), .pOutCredits(pOutCredits)) uBuf
	(
		.iSysClk(iSysClk), .rstN(rstN), .ufi(ufi), .slotFree(slotFree),
		.ufiOut(ufiOut), .ufiCreditRet(ufiCreditRet)
	);

endmodule

`default_nettype wire

// File: verification/spiMasterTasks.svh
//--------------------------------------------------------------------------
// SPI mode 0 master tasks, included inside the testbench module
// Frames go out from frameTx and the MISO words come back in frameRx
//--------------------------------------------------------------------------

	// Half an SPI bit in system clocks
	localparam int halfBit       = 8;
	localparam int maxFrameWords = 18;

	// Header opcodes for bits 31:30 of word 0
	localparam logic [1:0] opCsrWrite = 2'd1;
	localparam logic [1:0] opCsrRead  = 2'd2;
	localparam logic [1:0] opUfiWrite = 2'd3;

	logic [31:0] frameTx [maxFrameWords];
	logic [31:0] frameRx [maxFrameWords];

	// Header word, opcode on top and word count at the bottom
	function automatic logic [31:0] headerWord(input logic [1:0] op, input logic [15:0] len);
		return {op, 14'd0, len};
	endfunction

	// Lands 1 time unit after the n-th rising edge
	task automatic waitSysClocks(input int n);
		repeat (n) @(posedge iSysClk);
		#1;
	endtask

	// One word, MSB first, MOSI set while sclk is low
	task automatic shiftWord(input logic [31:0] txData, output logic [31:0] rxData);
		for (int i = 31; i >= 0; i--)
		begin
			mosi = txData[i];
			waitSysClocks(halfBit);
			// Master samples MISO at the rising edge
			rxData[i] = miso;
			sclk = 1'b1;
			waitSysClocks(halfBit);
			sclk = 1'b0;
		end
	endtask

	task automatic sendFrame(input int numWords);
		logic [31:0] rxData;
		waitSysClocks(1);
		csN = 1'b0;
		for (int w = 0; w < numWords; w++)
		begin
			shiftWord(frameTx[w], rxData);
			frameRx[w] = rxData;
		end
		waitSysClocks(halfBit);
		csN = 1'b1;
		// Idle gap before the next frame
		waitSysClocks(4 * halfBit);
	endtask

	task automatic csrWrite(input logic [31:0] adrs, input logic [31:0] data);
		frameTx[0] = headerWord(opCsrWrite, 16'd1);
		frameTx[1] = adrs;
		frameTx[2] = data;
		sendFrame(3);
	endtask

	task automatic csrRead(input logic [31:0] adrs, output logic [31:0] data);
		frameTx[0] = headerWord(opCsrRead, 16'd1);
		frameTx[1] = adrs;
		// Dummy word, MISO carries the read data
		frameTx[2] = 32'd0;
		sendFrame(3);
		data = frameRx[2];
	endtask

// File: verification/spiSlaveTb.sv
//--------------------------------------------------------------------------
// Testbench for the SPI slave subsystem, acts as SPI master and consumer
// Scoreboard checks ufiOut and CSR reads, credits come back after delays
//--------------------------------------------------------------------------
`default_nettype none

module spiSlaveTb import spiSlavePkg::*;
();

	localparam int pBufDepth   = 8;
	localparam int pOutCredits = 4;
	// Long enough to run out of slots and credits
	localparam int overBurst   = 16;

	logic   iSysClk;
	logic   rstN;
	logic   sclk;
	logic   mosi;
	logic   csN;
	logic   ufiCreditRet;
	logic   miso;
	ufiOutS ufiOut;

	int errorCount = 0;
	int checkCount = 0;
	// Consumer side bookkeeping
	int modelCredit    = pOutCredits;
	int creditsOwed    = 0;
	int deliveredCount = 0;
	int maxReturnDelay = 16;
	logic creditReturnOn = 1'b1;
	// {adrs, wd} of each word still expected on ufiOut
	logic [63:0] expWords [$];
	logic [31:0] csrData [4];
	logic [31:0] rdData;
	int unsigned seedDummy;
	// Raised when a wait runs out of time
	event  timeoutEvent;
	string timeoutWhat;

	`include "spiMasterTasks.svh"

	initial
	begin
		iSysClk = 1'b0;
		forever #2 iSysClk = ~iSysClk;
	end

	spiSlaveTop #(.pBufDepth(pBufDepth), .pOutCredits(pOutCredits)) UUT
	(
		.iSysClk(iSysClk), .rstN(rstN), .sclk(sclk), .mosi(mosi), .csN(csN),
		.ufiCreditRet(ufiCreditRet), .miso(miso), .ufiOut(ufiOut)
	);

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		assert (got === exp)
		else
		begin
			errorCount++;
			$display("Error %s: expected %h, got %h", name, exp, got);
		end
	endtask

	// Hands the report to the timeout process and parks the caller
	task automatic stopOnTimeout(input string what);
		timeoutWhat = what;
		-> timeoutEvent;
		forever @(posedge iSysClk);
	endtask

	task automatic waitQueueEmpty(input int limit);
		int cycles;
		cycles = 0;
		while ((expWords.size() != 0) && (cycles < limit))
		begin
			@(posedge iSysClk);
			cycles++;
		end
		if (expWords.size() != 0)
			stopOnTimeout("the expected UFI words to come out");
	endtask

	task automatic waitCreditsBack(input int limit);
		int cycles;
		cycles = 0;
		while ((creditsOwed != 0) && (cycles < limit))
		begin
			@(posedge iSysClk);
			cycles++;
		end
		if (creditsOwed != 0)
			stopOnTimeout("the consumer to return its credits");
	endtask

	task automatic waitDelivered(input int target, input int limit);
		int cycles;
		cycles = 0;
		while ((deliveredCount < target) && (cycles < limit))
		begin
			@(posedge iSysClk);
			cycles++;
		end
		if (deliveredCount < target)
			stopOnTimeout("words on ufiOut");
	endtask

	// Only the first numKept words are expected out
	task automatic ufiBurst(input logic [31:0] baseAdrs, input int numWords, input int numKept);
		logic [31:0] data;
		frameTx[0] = headerWord(opUfiWrite, 16'(numWords));
		frameTx[1] = baseAdrs;
		for (int w = 0; w < numWords; w++)
		begin
			data = $urandom();
			frameTx[w + 2] = data;
			if (w < numKept)
				expWords.push_back({baseAdrs + 32'(w), data});
		end
		sendFrame(numWords + 2);
	endtask

	//--------------------------------------------------------------------------
	// Consumer model, sampled mid cycle
	//--------------------------------------------------------------------------
	always @(negedge iSysClk)
	begin : consumerModel
		logic [63:0] expWord;
		if (rstN && ufiOut.valid)
		begin
			checkCount++;
			assert (modelCredit > 0)
			else
			begin
				errorCount++;
				$display("ufiOut.valid was high while the consumer held no credit");
			end
			deliveredCount++;
			creditsOwed++;
			checkCount++;
			assert (expWords.size() != 0)
			else
			begin
				errorCount++;
				$display("ufiOut delivered a word that was not expected");
			end
			if (expWords.size() != 0)
			begin
				expWord = expWords.pop_front();
				checkValue("ufiOut.wd", ufiOut.wd, expWord[31:0]);
				checkValue("ufiOut.adrs", ufiOut.adrs, expWord[63:32]);
			end
		end
		// Each transfer spends one, each return pulse adds one
		if (rstN)
			modelCredit = modelCredit + int'(ufiCreditRet) - int'(ufiOut.valid);
	end

	// Credit return after a random delay
	initial
	begin : creditReturn
		int returnDelay;
		forever
		begin
			@(posedge iSysClk);
			if (creditReturnOn && (creditsOwed > 0))
			begin
				returnDelay = $urandom_range(maxReturnDelay, 0);
				repeat (returnDelay) @(posedge iSysClk);
				if (creditReturnOn)
				begin
					#1 ufiCreditRet = 1'b1;
					creditsOwed--;
					@(posedge iSysClk);
					#1 ufiCreditRet = 1'b0;
				end
			end
		end
	end

	// Ends the run when a wait gives up
	initial
	begin : timeoutReport
		@(timeoutEvent);
		errorCount++;
		$display("Timeout while waiting for %s", timeoutWhat);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		$display("TEST FAIL");
		$finish;
	end

	//--------------------------------------------------------------------------
	// Test sequence
	//--------------------------------------------------------------------------
	initial
	begin
		sclk         = 1'b0;
		mosi         = 1'b0;
		csN          = 1'b1;
		ufiCreditRet = 1'b0;
		rstN         = 1'b0;
		seedDummy    = $urandom(32'h7a48de38);
		repeat (16) @(posedge iSysClk);
		#1 rstN = 1'b1;

		// Status after reset and unmapped space
		csrRead(32'd4, rdData);
		checkValue("csrRd[4]", rdData, 32'd0);
		csrRead(32'd6, rdData);
		checkValue("csrRd[6]", rdData, 32'd0);
		csrRead(32'h7f, rdData);
		checkValue("csrRd[7f]", rdData, 32'd0);

		// Scratch registers
		for (int a = 0; a < 4; a++)
		begin
			csrData[a] = $urandom();
			csrWrite(32'(a), csrData[a]);
		end
		for (int a = 0; a < 4; a++)
		begin
			csrRead(32'(a), rdData);
			checkValue($sformatf("csrRd[%0d]", a), rdData, csrData[a]);
		end

		// Burst with late credit returns
		maxReturnDelay = 1023;
		deliveredCount = 0;
		ufiBurst(32'h0000_1000, 6, 6);
		waitQueueEmpty(40000);
		waitCreditsBack(20000);
		checkValue("words delivered", 32'(deliveredCount), 32'd6);

		// Overflow with credits held back
		creditReturnOn = 1'b0;
		deliveredCount = 0;
		ufiBurst(32'h0000_2000, overBurst, pBufDepth + pOutCredits);
		waitDelivered(pOutCredits, 2000);
		csrRead(32'd4, rdData);
		checkValue("csrRd[4]", rdData, 32'd1);
		csrRead(32'd5, rdData);
		checkValue("csrRd[5]", rdData, 32'(overBurst - pBufDepth - pOutCredits));
		checkValue("words delivered", 32'(deliveredCount), 32'(pOutCredits));
		maxReturnDelay = 16;
		creditReturnOn = 1'b1;
		waitQueueEmpty(20000);
		waitCreditsBack(20000);
		checkValue("words delivered", 32'(deliveredCount), 32'(pBufDepth + pOutCredits));
		// Write 1 clears the flag
		csrWrite(32'd4, 32'd1);
		csrRead(32'd4, rdData);
		checkValue("csrRd[4]", rdData, 32'd0);

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verification
hw/spiSlavePkg.sv
hw/spiSlaveShift.sv
hw/spiSlaveCmd.sv
hw/spiSignalMux.sv
hw/csrRegFile.sv
hw/ufiWriteBuffer.sv
hw/spiSlaveTop.sv
verification/spiSlaveTb.sv

// File: Makefile
# Verilator build and run for the SPI slave subsystem

VERILATOR  ?= verilator
FILELIST   ?= sim.f
TB_TOP     ?= spiSlaveTb
RTL_TOP    ?= spiSlaveTop
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= TEST PASS
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
RTL_FILES  ?= $(shell grep '^hw/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o V$(TB_TOP)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
